/* Makefile */
# Verilator build and run of the exec_stage testbench
# The run exits nonzero when the testbench stops on a failure

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --assert -Wno-fatal --top-module exec_stage_tb \
		-f exec_stage.f --Mdir obj_dir -o exec_stage_tb
	./obj_dir/exec_stage_tb

clean:
	rm -rf obj_dir

/* design/alu.sv */
// Integer ALU for the execute stage; purely combinational
// Shifts use only the low SHAMT_W bits of the second operand

`timescale 1ns/1ps

module alu (
    input  logic [exec_pkg::XLEN-1:0] op_a_i,
    input  logic [exec_pkg::XLEN-1:0] op_b_i,
    input  logic [exec_pkg::XLEN-1:0] op_c_i,
    input  logic [exec_pkg::XLEN-1:0] pc_i,
    input  logic [exec_pkg::OP_W-1:0] op_i,
    output logic [exec_pkg::XLEN-1:0] sum_result_o,
    output logic [exec_pkg::XLEN-1:0] link_sum_o,
    output logic [exec_pkg::XLEN-1:0] alu_result_o,
    output logic                      cmp_eq_o,
    output logic                      cmp_lt_o,
    output logic                      cmp_ltu_o
);

    logic [exec_pkg::XLEN-1:0]    add2_a;
    logic [exec_pkg::XLEN-1:0]    add2_b;
    logic [exec_pkg::SHAMT_W-1:0] shamt;

    assign shamt = op_b_i[exec_pkg::SHAMT_W-1:0];

    // Main adder feeds addresses, JAL target and ADD
    assign sum_result_o = op_a_i + op_b_i;

    // Second adder: SUB, link address, or pc plus branch offset
    always_comb begin
        case (op_i)
            exec_pkg::OP_SUB: begin
                add2_a = op_a_i;
                add2_b = ~op_b_i + 1'b1;
            end
            exec_pkg::OP_JAL, exec_pkg::OP_JALR: begin
                add2_a = pc_i;
                add2_b = exec_pkg::LINK_OFFSET;
            end
            default: begin
                add2_a = pc_i;
                add2_b = op_c_i;
            end
        endcase
    end

    assign link_sum_o = add2_a + add2_b;

    assign cmp_eq_o  = (op_a_i == op_b_i);
    assign cmp_lt_o  = ($signed(op_a_i) < $signed(op_b_i));
    assign cmp_ltu_o = (op_a_i < op_b_i);

    ////////////////////////////////////////////////////////////
    // Register result select
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (op_i)
            exec_pkg::OP_SUB,
            exec_pkg::OP_JAL,
            exec_pkg::OP_JALR: alu_result_o = link_sum_o;
            exec_pkg::OP_AND:  alu_result_o = op_a_i & op_b_i;
            exec_pkg::OP_OR:   alu_result_o = op_a_i | op_b_i;
            exec_pkg::OP_XOR:  alu_result_o = op_a_i ^ op_b_i;
            exec_pkg::OP_SLL:  alu_result_o = op_a_i << shamt;
            exec_pkg::OP_SRL:  alu_result_o = op_a_i >> shamt;
            exec_pkg::OP_SRA:  alu_result_o = $unsigned($signed(op_a_i) >>> shamt);
            exec_pkg::OP_SLT:  alu_result_o = {{(exec_pkg::XLEN-1){1'b0}}, cmp_lt_o};
            exec_pkg::OP_SLTU: alu_result_o = {{(exec_pkg::XLEN-1){1'b0}}, cmp_ltu_o};
            // Immediate already shifted by decode
            exec_pkg::OP_LUI:  alu_result_o = op_b_i;
            default:           alu_result_o = sum_result_o;
        endcase
    end

endmodule

/* design/branch_unit.sv */
// Branch decision and jump target; combinational
// Jump is suppressed for killed instructions

`timescale 1ns/1ps

module branch_unit (
    input  logic [exec_pkg::OP_W-1:0] op_i,
    input  logic                      cmp_eq_i,
    input  logic                      cmp_lt_i,
    input  logic                      cmp_ltu_i,
    input  logic [exec_pkg::XLEN-1:0] sum_result_i,
    input  logic [exec_pkg::XLEN-1:0] link_sum_i,
    input  logic                      killed_i,
    output logic                      jump_o,
    output logic [exec_pkg::XLEN-1:0] jump_target_o
);

    logic take;

    always_comb begin
        case (op_i)
            exec_pkg::OP_BEQ:  take = cmp_eq_i;
            exec_pkg::OP_BNE:  take = ~cmp_eq_i;
            exec_pkg::OP_BLT:  take = cmp_lt_i;
            exec_pkg::OP_BLTU: take = cmp_ltu_i;
            exec_pkg::OP_BGE:  take = ~cmp_lt_i;
            exec_pkg::OP_BGEU: take = ~cmp_ltu_i;
            exec_pkg::OP_JAL,
            exec_pkg::OP_JALR: take = 1'b1;
            default:           take = 1'b0;
        endcase
    end

    assign jump_o = take & ~killed_i;

    // JALR clears bit 0; branches use pc + offset from the second adder
    always_comb begin
        case (op_i)
            exec_pkg::OP_JALR: jump_target_o = {sum_result_i[exec_pkg::XLEN-1:1], 1'b0};
            exec_pkg::OP_JAL:  jump_target_o = sum_result_i;
            default:           jump_target_o = link_sum_i;
        endcase
    end

endmodule

/* design/exec_pkg.sv */
// Execute stage word width and operation codes for RV32I without CSR, M or privileged ops
// Codes are plain vectors; decode must emit exactly these values

package exec_pkg;

    localparam int XLEN    = 32;
    localparam int OP_W    = 5;
    localparam int SHAMT_W = 5;

    // Return address step for JAL/JALR
    localparam logic [XLEN-1:0] LINK_OFFSET = 32'd4;

    ////////////////////////////////////////////////////////////
    // Operation codes
    ////////////////////////////////////////////////////////////

    // Register ops
    localparam logic [OP_W-1:0] OP_NOP  = 5'd0;
    localparam logic [OP_W-1:0] OP_ADD  = 5'd1;
    localparam logic [OP_W-1:0] OP_SUB  = 5'd2;
    localparam logic [OP_W-1:0] OP_AND  = 5'd3;
    localparam logic [OP_W-1:0] OP_OR   = 5'd4;
    localparam logic [OP_W-1:0] OP_XOR  = 5'd5;
    localparam logic [OP_W-1:0] OP_SLL  = 5'd6;
    localparam logic [OP_W-1:0] OP_SRL  = 5'd7;
    localparam logic [OP_W-1:0] OP_SRA  = 5'd8;
    localparam logic [OP_W-1:0] OP_SLT  = 5'd9;
    localparam logic [OP_W-1:0] OP_SLTU = 5'd10;
    localparam logic [OP_W-1:0] OP_LUI  = 5'd11;

    // Jumps and branches
    localparam logic [OP_W-1:0] OP_JAL  = 5'd12;
    localparam logic [OP_W-1:0] OP_JALR = 5'd13;
    localparam logic [OP_W-1:0] OP_BEQ  = 5'd14;
    localparam logic [OP_W-1:0] OP_BNE  = 5'd15;
    localparam logic [OP_W-1:0] OP_BLT  = 5'd16;
    localparam logic [OP_W-1:0] OP_BLTU = 5'd17;
    localparam logic [OP_W-1:0] OP_BGE  = 5'd18;
    localparam logic [OP_W-1:0] OP_BGEU = 5'd19;

    // Loads and stores
    localparam logic [OP_W-1:0] OP_LB   = 5'd20;
    localparam logic [OP_W-1:0] OP_LBU  = 5'd21;
    localparam logic [OP_W-1:0] OP_LH   = 5'd22;
    localparam logic [OP_W-1:0] OP_LHU  = 5'd23;
    localparam logic [OP_W-1:0] OP_LW   = 5'd24;
    localparam logic [OP_W-1:0] OP_SB   = 5'd25;
    localparam logic [OP_W-1:0] OP_SH   = 5'd26;
    localparam logic [OP_W-1:0] OP_SW   = 5'd27;

endpackage

/* design/exec_stage.sv */
// RV32I execute stage top; memory strobes and jump are combinational
// Register outputs lag one cycle and hold while stall_i is high

`timescale 1ns/1ps

module exec_stage #(
    parameter int TAG_W = 3
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stall_i,
    input  logic [exec_pkg::XLEN-1:0] pc_i,
    input  logic [exec_pkg::XLEN-1:0] op_a_i,
    input  logic [exec_pkg::XLEN-1:0] op_b_i,
    input  logic [exec_pkg::XLEN-1:0] op_c_i,
    input  logic [exec_pkg::OP_W-1:0] op_i,
    input  logic [TAG_W-1:0]          tag_i,
    output logic                      killed_o,
    output logic                      jump_o,
    output logic [exec_pkg::XLEN-1:0] jump_target_o,
    output logic [exec_pkg::XLEN-1:0] mem_address_o,
    output logic                      mem_read_enable_o,
    output logic [mem_pkg::BE_W-1:0]  mem_write_enable_o,
    output mem_pkg::store_word_u      mem_write_data_o,
    output logic                      write_enable_o,
    output logic [exec_pkg::OP_W-1:0] op_o,
    output logic [exec_pkg::XLEN-1:0] result_o
);

    logic [exec_pkg::XLEN-1:0] sum_result;
    logic [exec_pkg::XLEN-1:0] link_sum;
    logic [exec_pkg::XLEN-1:0] alu_result;
    logic                      cmp_eq;
    logic                      cmp_lt;
    logic                      cmp_ltu;
    logic                      killed;

    assign killed_o = killed;

    alu alu_i (
        .op_a_i(op_a_i), .op_b_i(op_b_i), .op_c_i(op_c_i), .pc_i(pc_i), .op_i(op_i),
        .sum_result_o(sum_result), .link_sum_o(link_sum), .alu_result_o(alu_result),
        .cmp_eq_o(cmp_eq), .cmp_lt_o(cmp_lt), .cmp_ltu_o(cmp_ltu)
    );

    branch_unit branch_unit_i (
        .op_i(op_i), .cmp_eq_i(cmp_eq), .cmp_lt_i(cmp_lt), .cmp_ltu_i(cmp_ltu),
        .sum_result_i(sum_result), .link_sum_i(link_sum), .killed_i(killed),
        .jump_o(jump_o), .jump_target_o(jump_target_o)
    );

    lsu_request lsu_request_i (
        .op_i(op_i), .sum_result_i(sum_result), .op_c_i(op_c_i),
        .mem_address_o(mem_address_o), .mem_read_enable_o(mem_read_enable_o),
        .mem_write_enable_o(mem_write_enable_o), .mem_write_data_o(mem_write_data_o)
    );

    // Taken jump starts a new flow
    flow_tag #(.TAG_W(TAG_W)) flow_tag_i (
        .clk(clk), .reset(reset), .jump_i(jump_o), .tag_i(tag_i), .killed_o(killed)
    );

    writeback_reg writeback_reg_i (
        .clk(clk), .reset(reset), .stall_i(stall_i), .killed_i(killed), .op_i(op_i),
        .result_i(alu_result), .write_enable_o(write_enable_o), .op_o(op_o),
        .result_o(result_o)
    );

endmodule

/* design/flow_tag.sv */
// Flow tag tracking; tag wraps modulo 2**TAG_W, TAG_W must be 2 or more
// Advances on every taken jump, even while the stage is stalled

`timescale 1ns/1ps

module flow_tag #(
    parameter int TAG_W = 3
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             jump_i,
    input  logic [TAG_W-1:0] tag_i,
    output logic             killed_o
);

    logic [TAG_W-1:0] curr_tag;

    always_ff @(posedge clk) begin
        if (reset) begin
            curr_tag <= '0;
        end else if (jump_i) begin
            curr_tag <= curr_tag + 1'b1;
        end
    end

    // Instruction fetched on an older flow
    assign killed_o = (curr_tag != tag_i);

endmodule

/* design/lsu_request.sv */
// Load/store request builder; combinational, word-aligned address out
// Store data is replicated into every lane so memory picks lanes by byte enable

`timescale 1ns/1ps

module lsu_request (
    input  logic [exec_pkg::OP_W-1:0]  op_i,
    input  logic [exec_pkg::XLEN-1:0]  sum_result_i,
    input  logic [exec_pkg::XLEN-1:0]  op_c_i,
    output logic [exec_pkg::XLEN-1:0]  mem_address_o,
    output logic                       mem_read_enable_o,
    output logic [mem_pkg::BE_W-1:0]   mem_write_enable_o,
    output mem_pkg::store_word_u       mem_write_data_o
);

    assign mem_address_o = {sum_result_i[exec_pkg::XLEN-1:2], 2'b00};

    assign mem_read_enable_o = op_i inside {exec_pkg::OP_LB, exec_pkg::OP_LBU,
                                            exec_pkg::OP_LH, exec_pkg::OP_LHU,
                                            exec_pkg::OP_LW};

    ////////////////////////////////////////////////////////////
    // Store enables and lane data
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (op_i)
            exec_pkg::OP_SB: begin
                mem_write_enable_o = mem_pkg::BE_BYTE0 << sum_result_i[1:0];
                mem_write_data_o.bytes = {mem_pkg::BE_W{op_c_i[7:0]}};
            end
            exec_pkg::OP_SH: begin
                // Address bit 1 picks the upper half
                mem_write_enable_o = sum_result_i[1] ? mem_pkg::BE_HALF_HI
                                                     : mem_pkg::BE_HALF_LO;
                mem_write_data_o.halves = {(mem_pkg::BE_W/2){op_c_i[15:0]}};
            end
            exec_pkg::OP_SW: begin
                mem_write_enable_o = mem_pkg::BE_ALL;
                mem_write_data_o   = op_c_i;
            end
            default: begin
                mem_write_enable_o = mem_pkg::BE_NONE;
                mem_write_data_o   = op_c_i;
            end
        endcase
    end

endmodule

/* design/mem_pkg.sv */
// Data memory request definitions for a 32-bit, byte-enabled, word-addressed port
// Store data lanes follow little-endian byte order

package mem_pkg;

    localparam int BE_W = 4;

    // Byte enable patterns
    localparam logic [BE_W-1:0] BE_NONE    = 4'b0000;
    localparam logic [BE_W-1:0] BE_BYTE0   = 4'b0001;
    localparam logic [BE_W-1:0] BE_HALF_LO = 4'b0011;
    localparam logic [BE_W-1:0] BE_HALF_HI = 4'b1100;
    localparam logic [BE_W-1:0] BE_ALL     = 4'b1111;

    ////////////////////////////////////////////////////////////
    // Store data word
    ////////////////////////////////////////////////////////////

    // Same 32 bits seen as byte lanes or as halfword lanes
    typedef union packed {
        logic [BE_W-1:0][7:0]    bytes;
        logic [BE_W/2-1:0][15:0] halves;
    } store_word_u;

endpackage

/* design/writeback_reg.sv */
// Execute output register; loads new values only when stall_i is low
// Result word carries no reset; only the enable and op are cleared

`timescale 1ns/1ps

module writeback_reg (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stall_i,
    input  logic                      killed_i,
    input  logic [exec_pkg::OP_W-1:0] op_i,
    input  logic [exec_pkg::XLEN-1:0] result_i,
    output logic                      write_enable_o,
    output logic [exec_pkg::OP_W-1:0] op_o,
    output logic [exec_pkg::XLEN-1:0] result_o
);

    logic write_enable;

    // No register write for stores and branches
    assign write_enable = ~killed_i
                        & ~(op_i inside {exec_pkg::OP_SB, exec_pkg::OP_SH, exec_pkg::OP_SW,
                                         exec_pkg::OP_BEQ, exec_pkg::OP_BNE,
                                         exec_pkg::OP_BLT, exec_pkg::OP_BLTU,
                                         exec_pkg::OP_BGE, exec_pkg::OP_BGEU});

    always_ff @(posedge clk) begin
        if (reset) begin
            write_enable_o <= 1'b0;
            op_o           <= exec_pkg::OP_NOP;
        end else if (!stall_i) begin
            write_enable_o <= write_enable;
            op_o           <= op_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            result_o <= result_i;
        end
    end

endmodule

/* exec_stage.f */
design/exec_pkg.sv
design/mem_pkg.sv
design/alu.sv
design/branch_unit.sv
design/lsu_request.sv
design/flow_tag.sv
design/writeback_reg.sv
design/exec_stage.sv
sim/exec_stage_sva.sv
sim/exec_stage_tb.sv

/* sim/exec_stage_sva.sv */
// Assertions bound into exec_stage; checks strobes, kill gating and reset

`timescale 1ns/1ps

module exec_stage_sva (
    input logic                     clk,
    input logic                     reset,
    input logic                     killed_o,
    input logic                     jump_o,
    input logic                     mem_read_enable_o,
    input logic [mem_pkg::BE_W-1:0] mem_write_enable_o,
    input logic                     write_enable_o
);

    // A request is either a read or a write
    a_read_or_write: assert property (@(posedge clk) disable iff (reset)
        !(mem_read_enable_o && (mem_write_enable_o != '0)))
        else $error("memory read and write requested together");

    a_no_jump_when_killed: assert property (@(posedge clk) disable iff (reset)
        !(jump_o && killed_o))
        else $error("jump raised for a killed instruction");

    a_reset_clears_we: assert property (@(posedge clk) reset |=> !write_enable_o)
        else $error("register write enable high after reset");

endmodule

bind exec_stage exec_stage_sva sva_i (
    .clk(clk), .reset(reset), .killed_o(killed_o), .jump_o(jump_o),
    .mem_read_enable_o(mem_read_enable_o), .mem_write_enable_o(mem_write_enable_o),
    .write_enable_o(write_enable_o)
);

/* sim/exec_stage_tb.sv */
// Random-vector testbench for exec_stage; stops at the first mismatch
// Combinational outputs are checked at the falling edge, registers one edge later

`timescale 1ns/1ps

module exec_stage_tb;

    localparam int TAG_W      = 3;
    localparam int N_VECTORS  = 2000;
    localparam int MAX_CYCLES = (N_VECTORS + 10) * 2;
    localparam int PAD_W      = exec_pkg::XLEN - exec_pkg::OP_W;

    logic                      clk;
    logic                      reset;
    logic                      stall;
    logic [exec_pkg::XLEN-1:0] pc;
    logic [exec_pkg::XLEN-1:0] op_a;
    logic [exec_pkg::XLEN-1:0] op_b;
    logic [exec_pkg::XLEN-1:0] op_c;
    logic [exec_pkg::OP_W-1:0] op;
    logic [TAG_W-1:0]          tag;
    logic                      killed;
    logic                      jump;
    logic [exec_pkg::XLEN-1:0] jump_target;
    logic [exec_pkg::XLEN-1:0] mem_address;
    logic                      mem_read_enable;
    logic [mem_pkg::BE_W-1:0]  mem_write_enable;
    mem_pkg::store_word_u      mem_write_data;
    logic                      write_enable;
    logic [exec_pkg::OP_W-1:0] op_out;
    logic [exec_pkg::XLEN-1:0] result;

    int seed = 4032;
    int cycles = 0;
    int checks = 0;

    // Expected register state and flow tag
    logic [TAG_W-1:0]          exp_tag;
    logic                      exp_we;
    logic [exec_pkg::OP_W-1:0] exp_op;
    logic [exec_pkg::XLEN-1:0] exp_result;
    logic                      result_known;

    exec_stage #(.TAG_W(TAG_W)) dut_i (
        .clk(clk), .reset(reset), .stall_i(stall), .pc_i(pc), .op_a_i(op_a),
        .op_b_i(op_b), .op_c_i(op_c), .op_i(op), .tag_i(tag), .killed_o(killed),
        .jump_o(jump), .jump_target_o(jump_target), .mem_address_o(mem_address),
        .mem_read_enable_o(mem_read_enable), .mem_write_enable_o(mem_write_enable),
        .mem_write_data_o(mem_write_data), .write_enable_o(write_enable),
        .op_o(op_out), .result_o(result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic check_word(input string name, input logic [exec_pkg::XLEN-1:0] got,
                              input logic [exec_pkg::XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Error: %s = %h, expected %h", name, got, exp);
            abort_run("word mismatch");
        end
    endtask

    task automatic check_strobe(input string name, input logic [mem_pkg::BE_W-1:0] got,
                                input logic [mem_pkg::BE_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Error: %s = %h, expected %h", name, got, exp);
            abort_run("strobe mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("Error: %s = %h, expected %h", name, got, exp);
            abort_run("bit mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic void reference_model(
        input  logic [exec_pkg::OP_W-1:0] f_op,
        input  logic [exec_pkg::XLEN-1:0] a,
        input  logic [exec_pkg::XLEN-1:0] b,
        input  logic [exec_pkg::XLEN-1:0] c,
        input  logic [exec_pkg::XLEN-1:0] pc_v,
        input  logic                      f_killed,
        output logic [exec_pkg::XLEN-1:0] f_result,
        output logic                      f_jump,
        output logic [exec_pkg::XLEN-1:0] f_target,
        output logic [exec_pkg::XLEN-1:0] f_addr,
        output logic                      f_rd,
        output logic [mem_pkg::BE_W-1:0]  f_be,
        output mem_pkg::store_word_u      f_data,
        output logic                      f_we
    );
        logic [exec_pkg::XLEN-1:0]    sum;
        logic [exec_pkg::SHAMT_W-1:0] sh;
        logic                         taken;
        sum = a + b;
        sh = b[exec_pkg::SHAMT_W-1:0];
        taken = 1'b0;
        f_result = sum;
        f_be = 4'b0000;
        f_data = c;
        f_we = ~f_killed;
        case (f_op)
            exec_pkg::OP_SUB:  f_result = a - b;
            exec_pkg::OP_AND:  f_result = a & b;
            exec_pkg::OP_OR:   f_result = a | b;
            exec_pkg::OP_XOR:  f_result = a ^ b;
            exec_pkg::OP_SLL:  f_result = a << sh;
            exec_pkg::OP_SRL:  f_result = a >> sh;
            exec_pkg::OP_SRA:  f_result = $unsigned($signed(a) >>> sh);
            exec_pkg::OP_SLT:  f_result = {31'd0, $signed(a) < $signed(b)};
            exec_pkg::OP_SLTU: f_result = {31'd0, a < b};
            exec_pkg::OP_LUI:  f_result = b;
            exec_pkg::OP_JAL, exec_pkg::OP_JALR: begin
                f_result = pc_v + 32'd4;
                taken = 1'b1;
            end
            exec_pkg::OP_BEQ:  taken = (a == b);
            exec_pkg::OP_BNE:  taken = (a != b);
            exec_pkg::OP_BLT:  taken = ($signed(a) < $signed(b));
            exec_pkg::OP_BLTU: taken = (a < b);
            exec_pkg::OP_BGE:  taken = ($signed(a) >= $signed(b));
            exec_pkg::OP_BGEU: taken = (a >= b);
            exec_pkg::OP_SB: begin
                f_be = 4'b0001 << sum[1:0];
                f_data.bytes = {mem_pkg::BE_W{c[7:0]}};
            end
            exec_pkg::OP_SH: begin
                f_be = sum[1] ? 4'b1100 : 4'b0011;
                f_data.halves = {(mem_pkg::BE_W/2){c[15:0]}};
            end
            exec_pkg::OP_SW:   f_be = 4'b1111;
            default:           f_result = sum;
        endcase
        // Stores and branches never write a register
        if (f_op inside {exec_pkg::OP_SB, exec_pkg::OP_SH, exec_pkg::OP_SW, exec_pkg::OP_BEQ,
                         exec_pkg::OP_BNE, exec_pkg::OP_BLT, exec_pkg::OP_BLTU,
                         exec_pkg::OP_BGE, exec_pkg::OP_BGEU}) begin
            f_we = 1'b0;
        end
        f_jump = taken & ~f_killed;
        if (f_op == exec_pkg::OP_JALR) begin
            f_target = {sum[exec_pkg::XLEN-1:1], 1'b0};
        end else if (f_op == exec_pkg::OP_JAL) begin
            f_target = sum;
        end else begin
            f_target = pc_v + c;
        end
        f_addr = {sum[exec_pkg::XLEN-1:2], 2'b00};
        f_rd = f_op inside {exec_pkg::OP_LB, exec_pkg::OP_LBU, exec_pkg::OP_LH,
                            exec_pkg::OP_LHU, exec_pkg::OP_LW};
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic drive_vector();
        logic [31:0]               r;
        logic [7:0]                op_sel;
        logic [exec_pkg::XLEN-1:0] a;
        r = $random(seed);
        a = $random(seed);
        op_sel = r[15:8] % 8'd28;
        stall <= (r[2:0] == 3'd0);
        op    <= op_sel[exec_pkg::OP_W-1:0];
        op_a  <= a;
        // Equal operands now and then so BEQ and BGE get taken
        op_b  <= (r[17:16] == 2'd0) ? a : $random(seed);
        op_c  <= $random(seed);
        pc    <= $random(seed) & 32'hFFFF_FFFC;
        // Stale tag about one vector in sixteen
        tag   <= (r[6:3] == 4'd0) ? exp_tag ^ {r[20 +: TAG_W-1], 1'b1} : exp_tag;
    endtask

    initial begin
        reset = 1'b1;
        stall = 1'b0;
        pc    = '0;
        op_a  = '0;
        op_b  = '0;
        op_c  = '0;
        op    = exec_pkg::OP_NOP;
        tag   = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        repeat (N_VECTORS) begin
            @(posedge clk);
            drive_vector();
        end
        // Drain the last vector through the output register
        @(posedge clk);
        stall <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        #1;
        if (checks > 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("No checks were run");
            abort_run("empty run");
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: run exceeded %0d cycles", MAX_CYCLES);
            abort_run("cycle limit reached");
        end
    end

    ////////////////////////////////////////////////////////////
    // Compare
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin : compare
        logic [exec_pkg::XLEN-1:0] r_result;
        logic [exec_pkg::XLEN-1:0] r_target;
        logic [exec_pkg::XLEN-1:0] r_addr;
        logic                      r_jump;
        logic                      r_rd;
        logic                      r_we;
        logic                      r_killed;
        logic [mem_pkg::BE_W-1:0]  r_be;
        mem_pkg::store_word_u      r_data;
        if (reset !== 1'b0) begin
            exp_tag = '0;
            exp_we = 1'b0;
            exp_op = exec_pkg::OP_NOP;
            result_known = 1'b0;
        end else begin
            // Registers hold what the last unstalled edge captured
            check_bit("write_enable_o", write_enable, exp_we);
            check_word("op_o", {{PAD_W{1'b0}}, op_out}, {{PAD_W{1'b0}}, exp_op});
            if (result_known) begin
                check_word("result_o", result, exp_result);
            end
            r_killed = (tag != exp_tag);
            reference_model(op, op_a, op_b, op_c, pc, r_killed, r_result, r_jump,
                            r_target, r_addr, r_rd, r_be, r_data, r_we);
            check_bit("killed_o", killed, r_killed);
            check_bit("jump_o", jump, r_jump);
            // Target only defined for jumps and branches
            if (op inside {exec_pkg::OP_JAL, exec_pkg::OP_JALR, exec_pkg::OP_BEQ,
                           exec_pkg::OP_BNE, exec_pkg::OP_BLT, exec_pkg::OP_BLTU,
                           exec_pkg::OP_BGE, exec_pkg::OP_BGEU}) begin
                check_word("jump_target_o", jump_target, r_target);
            end
            check_word("mem_address_o", mem_address, r_addr);
            check_bit("mem_read_enable_o", mem_read_enable, r_rd);
            check_strobe("mem_write_enable_o", mem_write_enable, r_be);
            check_word("mem_write_data_o", mem_write_data, r_data);
            if (!stall) begin
                exp_we = r_we;
                exp_op = op;
                exp_result = r_result;
                result_known = 1'b1;
            end
            // Tag moves on a taken jump, stalled or not
            if (r_jump) begin
                exp_tag = exp_tag + TAG_W'(1);
            end
        end
    end

endmodule
